//--- bench/fdc_tests.txt
# op addr data expect, all hex; m=mount (data=size, expect=readonly) w=write r=read-compare
# i=wait for intrq, s=read sector stream (data=command, expect=block address)
r 3ffc 00 ff
w 3ffc 01 00
r 3ffc 00 fe
w 3ffd 80 00
r 3ffd 00 fb
r 1ff8 00 ff
r 3ffe 00 ff
r 3ff8 00 a0
w 3ff8 00 00
i 0000 00 00
r 3fff 00 bf
r 3ff8 00 a0
r 3fff 00 ff
m 0000 0 0
r 3ff8 00 a0
m 0000 c8000 0
r 3ff8 00 20
w 3ffd 81 00
r 3ffd 00 fa
r 3ff8 00 a0
w 3ffd 80 00
w 3ffb 05 00
w 3ff8 10 00
i 0000 00 00
r 3ff9 00 05
r 3ff8 00 00
r 3fff 00 ff
w 3ff8 00 00
i 0000 00 00
r 3ff9 00 00
r 3ff8 00 20
w 3ffb 03 00
w 3ff8 10 00
i 0000 00 00
r 3ff8 00 00
w 3ffa 05 00
s 3ff8 80 25
i 0000 00 00
r 3ff8 00 00
w 3ffc 00 00
w 3ffa 02 00
s 3ff8 80 1e
i 0000 00 00
r 3ff8 00 00
w 3ffa 00 00
w 3ff8 80 00
i 0000 00 00
r 3ff8 00 10
m 0000 c8000 1
r 3ff8 00 50
w 3ffa 01 00
w 3ff8 80 00
w 3ff8 d0 00
i 0000 00 00
r 3ff8 00 40
r 3fff 00 ff

//--- sim.f
+incdir+hw
hw/fdc_bus_pkg.sv
hw/fdc_disk_pkg.sv
hw/fdc_drive_latch.sv
hw/wd_core.sv
hw/wd_sector_fetch.sv
hw/fdc.sv
bench/fdc_checker.sv
bench/tb_fdc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the fdc testbench with Verilator, run it and check the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter the project directory"
   exit 1
fi

verilator --binary --timing -j 0 --top-module tb_fdc -f sim.f -o tb_fdc
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_fdc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
   exit 0
fi
exit 1

//--- bench/tb_fdc.sv
`default_nettype none
`timescale 1ns/1ps
`include "fdc_config.svh"

module tb_fdc;

   // the DUT clocks on port reset and resets on port clk
   logic        reset;
   logic        clk;
   logic        clk_en;
   logic        cs;
   logic [13:0] addr;
   logic [7:0]  d_from_cpu;
   logic [7:0]  d_to_cpu;
   logic        output_en;
   logic        rd;
   logic        wr;
   logic        img_mounted;
   logic [31:0] img_size;
   logic        img_readonly;
   logic [31:0] sd_lba;
   logic        sd_rd;
   logic        sd_ack;
   logic [8:0]  sd_buff_addr;
   logic [7:0]  sd_buff_dout;
   logic        sd_buff_wr;
   logic        cmp_en;
   logic [7:0]  cmp_exp;
   logic        stream_en;
   logic        lba_arm;
   logic [31:0] lba_exp;
   integer      value_errs;
   integer      lba_errs;
   integer      file_errs;
   integer      cycles;
   integer      cycle_limit;

   fdc i_fdc (.*);

   fdc_checker i_checker (.*);

   always #10 reset = ~reset;

   always @(posedge reset) begin
      cycles = cycles + 1;
      if (cycle_limit > 0 && cycles > cycle_limit) begin
         $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   // SD host, answers a block request after a few cycles
   always begin
      @(negedge reset);
      if (sd_rd && !sd_ack) begin
         repeat (3) @(posedge reset);
         #1;
         sd_ack = 1'b1;
         for (int i = 0; i < 512; i++) begin
            @(posedge reset);
            #1;
            sd_buff_wr   = 1'b1;
            sd_buff_addr = 9'(i);
            sd_buff_dout = sd_lba[7:0] ^ 8'(i);
         end
         @(posedge reset);
         #1;
         sd_buff_wr = 1'b0;
         sd_ack     = 1'b0;
      end
   end

   // one strobe cycle followed by one idle cycle
   task automatic bus_cycle(input logic is_wr, input logic [13:0] a, input logic [7:0] wd,
                            input logic chk, input logic strm, output logic [7:0] rdata);
      @(posedge reset);
      #1;
      cs         = 1'b1;
      rd         = ~is_wr;
      wr         = is_wr;
      addr       = a;
      d_from_cpu = wd;
      cmp_en     = chk;
      stream_en  = strm;
      @(negedge reset);
      rdata = d_to_cpu;
      @(posedge reset);
      #1;
      cs        = 1'b0;
      rd        = 1'b0;
      wr        = 1'b0;
      cmp_en    = 1'b0;
      stream_en = 1'b0;
   endtask

   // 0xFFF carries drq and intrq inverted
   task automatic wait_status_bit(input int bit_pos);
      logic [7:0] v;
      v = 8'hff;
      while (v[bit_pos] == 1'b1) begin
         bus_cycle(1'b0, 14'h3fff, 8'h00, 1'b0, 1'b0, v);
      end
   endtask

   task automatic read_sector_stream(input logic [13:0] a, input logic [7:0] cmd,
                                     input logic [31:0] lba);
      logic [7:0] v;
      lba_exp = lba;
      lba_arm = 1'b1;
      bus_cycle(1'b1, a, cmd, 1'b0, 1'b0, v);
      for (int n = 0; n < `FDC_SECTOR_BYTES; n++) begin
         wait_status_bit(7);
         bus_cycle(1'b0, 14'h3ffb, 8'h00, 1'b0, 1'b1, v);
      end
      lba_arm = 1'b0;
   endtask

   task automatic mount_image(input logic [31:0] size, input logic ro);
      @(posedge reset);
      #1;
      img_mounted  = 1'b1;
      img_size     = size;
      img_readonly = ro;
      @(posedge reset);
      #1;
      img_mounted = 1'b0;
   endtask

   task automatic run_test(input logic [7:0] op, input logic [13:0] a, input logic [31:0] d,
                           input logic [31:0] e);
      logic [7:0] v;
      case (op)
         "m": mount_image(d, e[0]);
         "w": bus_cycle(1'b1, a, d[7:0], 1'b0, 1'b0, v);
         "r": begin
            cmp_exp = e[7:0];
            bus_cycle(1'b0, a, 8'h00, 1'b1, 1'b0, v);
         end
         "i": wait_status_bit(6);
         "s": read_sector_stream(a, d[7:0], e);
         default: begin
            $display("unknown operation code %c in the test file", op);
            file_errs = file_errs + 1;
         end
      endcase
   endtask

   initial begin
      int          fd;
      int          c;
      int          n;
      logic [7:0]  op;
      logic [13:0] a;
      logic [31:0] d;
      logic [31:0] e;
      reset        = 1'b0;
      clk          = 1'b1;
      clk_en       = 1'b1;
      cs           = 1'b0;
      addr         = '0;
      d_from_cpu   = '0;
      rd           = 1'b0;
      wr           = 1'b0;
      img_mounted  = 1'b0;
      img_size     = '0;
      img_readonly = 1'b0;
      sd_ack       = 1'b0;
      sd_buff_addr = '0;
      sd_buff_dout = '0;
      sd_buff_wr   = 1'b0;
      cmp_en       = 1'b0;
      cmp_exp      = '0;
      stream_en    = 1'b0;
      lba_arm      = 1'b0;
      lba_exp      = '0;
      file_errs    = 0;
      cycles       = 0;
      cycle_limit  = 0;
      fd = $fopen("bench/fdc_tests.txt", "r");
      if (fd == 0) begin
         $display("could not open bench/fdc_tests.txt");
         $display("TEST RESULT: FAIL");
         $finish;
      end else begin
         // every line of the file gets its own share of cycles
         n = 0;
         c = $fgetc(fd);
         while (c != -1) begin
            if (c == 10) n = n + 1;
            c = $fgetc(fd);
         end
         $fclose(fd);
         cycle_limit = n * `FDC_TEST_CYCLES;
         fd = $fopen("bench/fdc_tests.txt", "r");
         repeat (4) @(posedge reset);
         #1;
         clk = 1'b0;
         c = $fgetc(fd);
         while (c != -1) begin
            // 35 is '#', anything at or below 32 is white space
            if (c == 35) begin
               while (c != 10 && c != -1) c = $fgetc(fd);
            end else if (c > 32) begin
               op = 8'(c);
               n  = $fscanf(fd, " %h %h %h", a, d, e);
               run_test(op, a, d, e);
            end
            c = $fgetc(fd);
         end
         $fclose(fd);
         repeat (2) @(posedge reset);
         $display("errors: %0d value, %0d block address, %0d test file",
                  value_errs, lba_errs, file_errs);
         if (value_errs == 0 && lba_errs == 0 && file_errs == 0) begin
            $display("TEST RESULT: PASS");
         end else begin
            $display("TEST RESULT: FAIL");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- bench/fdc_checker.sv
`default_nettype none
`timescale 1ns/1ps
`include "fdc_config.svh"

module fdc_checker
   import fdc_bus_pkg::*;
   import fdc_disk_pkg::*;
(
   input  logic        reset,
   input  logic        clk,
   input  logic        cs,
   input  logic        rd,
   input  logic [13:0] addr,
   input  logic [7:0]  d_to_cpu,
   input  logic        output_en,
   input  logic        sd_rd,
   input  logic [31:0] sd_lba,
   input  logic        cmp_en,
   input  byte_t       cmp_exp,
   input  logic        stream_en,
   input  logic        lba_arm,
   input  logic [31:0] lba_exp,
   output integer      value_errs,
   output integer      lba_errs
);

   logic       sd_rd_q;
   logic       arm_q;
   logic       lba_seen;
   logic [8:0] byte_idx;

   // only the seven active offsets of the window drive the bus
   function automatic logic window_hit(input logic [13:0] a);
      return (a[13:12] == 2'b11) &&
             ((a[11:0] >= io_wd_base && a[11:0] <= io_drive) || a[11:0] == io_status);
   endfunction

   // sampled on the falling clock edge, halfway through each strobe
   always @(negedge reset or posedge clk) begin
      if (clk) begin
         value_errs <= 0;
         lba_errs   <= 0;
         sd_rd_q    <= 1'b0;
         arm_q      <= 1'b0;
         lba_seen   <= 1'b0;
         byte_idx   <= '0;
      end else begin
         sd_rd_q <= sd_rd;
         arm_q   <= lba_arm;
         if (cs && rd && cmp_en) begin
            if (output_en !== window_hit(addr) || d_to_cpu !== cmp_exp) begin
               $display("ERR %0t: read of %h gave %h oe %b, expected %h oe %b", $time,
                        addr, d_to_cpu, output_en, cmp_exp, window_hit(addr));
               value_errs <= value_errs + 1;
            end
         end
         // half * 256 drops out of the low byte, leaving the byte index
         if (cs && rd && stream_en) begin
            if (d_to_cpu !== (lba_exp[7:0] ^ byte_idx[7:0])) begin
               $display("ERR %0t: sector byte %0d read %h, expected %h", $time,
                        byte_idx, d_to_cpu, lba_exp[7:0] ^ byte_idx[7:0]);
               value_errs <= value_errs + 1;
            end
            byte_idx <= byte_idx + 9'd1;
         end
         if (lba_arm && sd_rd && !sd_rd_q) begin
            lba_seen <= 1'b1;
            if (sd_lba !== lba_exp) begin
               $display("ERR %0t: block request for lba %0d, expected %0d", $time,
                        sd_lba, lba_exp);
               lba_errs <= lba_errs + 1;
            end
         end
         // end of a sector read
         if (arm_q && !lba_arm) begin
            if (!lba_seen) begin
               $display("no SD block request was seen during the sector read");
               lba_errs <= lba_errs + 1;
            end
            lba_seen <= 1'b0;
            byte_idx <= '0;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/fdc.sv
`default_nettype none
`timescale 1ns/1ps

module fdc
   import fdc_bus_pkg::*;
   import fdc_disk_pkg::*;
(
   input  logic        reset,
   input  logic        clk,
   input  logic        clk_en,
   input  logic        cs,
   input  logic [13:0] addr,
   input  logic [7:0]  d_from_cpu,
   output logic [7:0]  d_to_cpu,
   output logic        output_en,
   input  logic        rd,
   input  logic        wr,
   input  logic        img_mounted,
   input  logic [31:0] img_size,
   input  logic        img_readonly,
   output logic [31:0] sd_lba,
   output logic        sd_rd,
   input  logic        sd_ack,
   input  logic [8:0]  sd_buff_addr,
   input  logic [7:0]  sd_buff_dout,
   input  logic        sd_buff_wr
);

   logic    io_en;
   logic    wd_sel;
   logic    side_sel;
   logic    drive_sel_en;
   logic    status_sel;
   logic    side;
   logic    motor_on;
   logic    fdd_ready;
   logic    drq;
   logic    intrq;
   logic    fetch_start;
   logic    fetch_side;
   logic    fetch_done;
   logic    byte_take;
   logic [1:0] drive_sel;
   byte_t   wd_rdata;
   byte_t   byte_data;
   track_t  fetch_track;
   sector_t fetch_sector;

   assign io_en        = cs & (addr[13:12] == 2'b11);
   assign wd_sel       = io_en & (addr[11:2] == io_wd_base[11:2]);
   assign side_sel     = io_en & (addr[11:0] == io_side);
   assign drive_sel_en = io_en & (addr[11:0] == io_drive);
   assign status_sel   = io_en & (addr[11:0] == io_status);

   // read mux, everything outside the active offsets floats high
   assign {output_en, d_to_cpu} = status_sel   ? {1'b1, ~drq, ~intrq, 6'b111111}     :
                                  side_sel     ? {1'b1, 7'b1111111, ~side}           :
                                  drive_sel_en ? {1'b1, motor_on, 5'b11110, ~drive_sel} :
                                  wd_sel       ? {1'b1, wd_rdata}                    :
                                                 9'h0ff;

   fdc_drive_latch i_drive_latch (
      .reset       (reset),
      .clk         (clk),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .side_wr     (side_sel & clk_en & wr),
      .drive_wr    (drive_sel_en & clk_en & wr),
      .wdata       (d_from_cpu),
      .side        (side),
      .drive_sel   (drive_sel),
      .motor_on    (motor_on),
      .fdd_ready   (fdd_ready)
   );

   wd_core i_wd_core (
      .reset        (reset),
      .clk          (clk),
      .clk_en       (clk_en),
      .sel          (wd_sel),
      .rd           (rd),
      .wr           (wr),
      .reg_sel      (wd_reg_e'(addr[1:0])),
      .wdata        (d_from_cpu),
      .rdata        (wd_rdata),
      .drq          (drq),
      .intrq        (intrq),
      .fdd_ready    (fdd_ready),
      .write_prot   (img_readonly),
      .side         (side),
      .fetch_start  (fetch_start),
      .fetch_track  (fetch_track),
      .fetch_side   (fetch_side),
      .fetch_sector (fetch_sector),
      .fetch_done   (fetch_done),
      .byte_take    (byte_take),
      .byte_data    (byte_data)
   );

   wd_sector_fetch i_sector_fetch (
      .reset        (reset),
      .clk          (clk),
      .fetch_start  (fetch_start),
      .fetch_track  (fetch_track),
      .fetch_side   (fetch_side),
      .fetch_sector (fetch_sector),
      .fetch_done   (fetch_done),
      .byte_take    (byte_take),
      .byte_data    (byte_data),
      .sd_lba       (sd_lba),
      .sd_rd        (sd_rd),
      .sd_ack       (sd_ack),
      .sd_buff_addr (sd_buff_addr),
      .sd_buff_dout (sd_buff_dout),
      .sd_buff_wr   (sd_buff_wr)
   );

endmodule

`default_nettype wire

//--- hw/wd_sector_fetch.sv
`default_nettype none
`timescale 1ns/1ps
`include "fdc_config.svh"

module wd_sector_fetch
   import fdc_disk_pkg::*;
(
   input  logic        reset,
   input  logic        clk,
   input  logic        fetch_start,
   input  track_t      fetch_track,
   input  logic        fetch_side,
   input  sector_t     fetch_sector,
   output logic        fetch_done,
   input  logic        byte_take,
   output byte_t       byte_data,
   output logic [31:0] sd_lba,
   output logic        sd_rd,
   input  logic        sd_ack,
   input  logic [8:0]  sd_buff_addr,
   input  byte_t       sd_buff_dout,
   input  logic        sd_buff_wr
);

   typedef enum logic [1:0] {f_idle, f_req, f_ack} fstate_e;

   fstate_e     state;
   logic [11:0] sec_index;
   logic [31:0] next_lba;
   logic        next_half;
   logic        req_half;
   logic        pending;
   logic [7:0]  rd_ptr;
   byte_t       ram [`FDC_SECTOR_BYTES];

   // two sectors share one 512 byte block
   assign sec_index = (12'(fetch_track) * 12'(`FDC_SIDES) + 12'(fetch_side))
                      * 12'(`FDC_SECTORS_PER_TRACK) + 12'(fetch_sector) - 12'd1;

   always_ff @(posedge reset) begin
      if (fetch_start) begin
         next_lba  <= 32'(sec_index[11:1]);
         next_half <= sec_index[0];
      end
      if (state == f_idle && pending) begin
         sd_lba   <= next_lba;
         req_half <= next_half;
      end
      if (sd_ack && sd_buff_wr && state != f_idle && sd_buff_addr[8] == req_half) begin
         ram[sd_buff_addr[7:0]] <= sd_buff_dout;
      end
      byte_data <= ram[byte_take ? rd_ptr + 8'd1 : rd_ptr];
   end

   // a start that lands mid-transfer reruns the request once the block is in
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         state      <= f_idle;
         pending    <= 1'b0;
         sd_rd      <= 1'b0;
         fetch_done <= 1'b0;
         rd_ptr     <= '0;
      end else begin
         fetch_done <= 1'b0;
         case (state)
            f_idle: begin
               if (pending) begin
                  pending <= 1'b0;
                  sd_rd   <= 1'b1;
                  state   <= f_req;
               end
            end
            f_req: begin
               if (sd_ack) begin
                  sd_rd <= 1'b0;
                  state <= f_ack;
               end
            end
            default: begin
               if (!sd_ack) begin
                  fetch_done <= !pending && !fetch_start;
                  state      <= f_idle;
               end
            end
         endcase
         if (fetch_start) begin
            pending <= 1'b1;
            rd_ptr  <= '0;
         end else if (byte_take) begin
            rd_ptr <= rd_ptr + 8'd1;
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/wd_core.sv
`default_nettype none
`timescale 1ns/1ps
`include "fdc_config.svh"

module wd_core
   import fdc_bus_pkg::*;
   import fdc_disk_pkg::*;
(
   input  logic    reset,
   input  logic    clk,
   input  logic    clk_en,
   input  logic    sel,
   input  logic    rd,
   input  logic    wr,
   input  wd_reg_e reg_sel,
   input  byte_t   wdata,
   output byte_t   rdata,
   output logic    drq,
   output logic    intrq,
   input  logic    fdd_ready,
   input  logic    write_prot,
   input  logic    side,
   output logic    fetch_start,
   output track_t  fetch_track,
   output logic    fetch_side,
   output sector_t fetch_sector,
   input  logic    fetch_done,
   output logic    byte_take,
   input  byte_t   byte_data
);

   typedef enum logic [1:0] {s_idle, s_step, s_fetch, s_xfer} state_e;

   state_e     state;
   wd_cmd_e    cmd_r;
   wd_cmd_e    cmd_in;
   track_t     track_r;
   track_t     seek_track;
   sector_t    sector_r;
   byte_t      data_r;
   byte_t      status_byte;
   logic       busy;
   logic       rnf;
   logic [7:0] byte_cnt;
   logic       cpu_rd;
   logic       cpu_wr;
   logic       cmd_wr;
   logic       sector_ok;

   assign cpu_rd    = clk_en & sel & rd;
   assign cpu_wr    = clk_en & sel & wr;
   assign cmd_wr    = cpu_wr & (reg_sel == reg_status_cmd);
   assign cmd_in    = decode_cmd(wdata);
   assign byte_take = cpu_rd & (reg_sel == reg_data) & drq;
   assign sector_ok = (sector_r != 8'd0) && (sector_r <= 8'(`FDC_SECTORS_PER_TRACK));

   // head stops at the last track
   assign seek_track = (data_r < 8'(`FDC_TRACKS)) ? track_t'(data_r)
                                                  : track_t'(`FDC_TRACKS - 1);

   assign fetch_track  = track_r;
   assign fetch_side   = side;
   assign fetch_sector = sector_r;

   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         state       <= s_idle;
         cmd_r       <= cmd_unsupported;
         track_r     <= '0;
         sector_r    <= '0;
         data_r      <= '0;
         busy        <= 1'b0;
         drq         <= 1'b0;
         intrq       <= 1'b0;
         rnf         <= 1'b0;
         byte_cnt    <= '0;
         fetch_start <= 1'b0;
      end else begin
         fetch_start <= 1'b0;
         if (cpu_rd && reg_sel == reg_status_cmd) begin
            intrq <= 1'b0;
         end
         if (cpu_wr) begin
            case (reg_sel)
               reg_track:  track_r  <= track_t'(wdata);
               reg_sector: sector_r <= wdata;
               reg_data:   data_r   <= wdata;
               default:    ;
            endcase
         end
         // last byte handed out stays readable in the data register
         if (byte_take) begin
            data_r <= byte_data;
         end

         case (state)
            s_step: begin
               if (clk_en) begin
                  if (busy && cmd_r == cmd_restore) begin
                     track_r <= '0;
                  end
                  if (busy && cmd_r == cmd_seek) begin
                     track_r <= seek_track;
                  end
                  busy  <= 1'b0;
                  intrq <= 1'b1;
                  state <= s_idle;
               end
            end
            s_fetch: begin
               if (fetch_done) begin
                  drq      <= 1'b1;
                  byte_cnt <= '0;
                  state    <= s_xfer;
               end
            end
            s_xfer: begin
               if (byte_take) begin
                  drq      <= 1'b0;
                  byte_cnt <= byte_cnt + 8'd1;
                  if (byte_cnt == 8'(`FDC_SECTOR_BYTES - 1)) begin
                     busy  <= 1'b0;
                     intrq <= 1'b1;
                     state <= s_idle;
                  end
               end else if (!drq) begin
                  // rearm one cycle after each byte is taken
                  drq <= 1'b1;
               end
            end
            default: ;
         endcase

         // a new command wins over whatever the state machine did above
         if (cmd_wr && (!busy || cmd_in == cmd_force_int)) begin
            cmd_r <= cmd_in;
            intrq <= 1'b0;
            rnf   <= 1'b0;
            drq   <= 1'b0;
            case (cmd_in)
               cmd_force_int: begin
                  busy  <= 1'b0;
                  intrq <= 1'b1;
                  state <= s_idle;
               end
               cmd_restore, cmd_seek: begin
                  busy  <= fdd_ready;
                  state <= s_step;
               end
               cmd_read_sector: begin
                  if (!fdd_ready) begin
                     state <= s_step;
                  end else if (!sector_ok) begin
                     rnf   <= 1'b1;
                     state <= s_step;
                  end else begin
                     busy        <= 1'b1;
                     fetch_start <= 1'b1;
                     state       <= s_fetch;
                  end
               end
               default: state <= s_step;
            endcase
         end
      end
   end

   // no write path, so lost data and crc never assert
   always_comb begin
      status_byte                      = '0;
      status_byte[st_busy]             = busy;
      status_byte[st_drq]              = drq;
      status_byte[st_lost_data]        = 1'b0;
      status_byte[st_crc]              = 1'b0;
      status_byte[st_record_not_found] = rnf;
      status_byte[st_track0]           = (track_r == '0);
      status_byte[st_write_protect]    = write_prot;
      status_byte[st_not_ready]        = ~fdd_ready;
   end

   always_comb begin
      case (reg_sel)
         reg_status_cmd: rdata = status_byte;
         reg_track:      rdata = {1'b0, track_r};
         reg_sector:     rdata = sector_r;
         default:        rdata = drq ? byte_data : data_r;
      endcase
   end

endmodule

`default_nettype wire

//--- hw/fdc_drive_latch.sv
`default_nettype none
`timescale 1ns/1ps

module fdc_drive_latch
   import fdc_disk_pkg::*;
(
   input  logic        reset,
   input  logic        clk,
   input  logic        img_mounted,
   input  logic [31:0] img_size,
   input  logic        side_wr,
   input  logic        drive_wr,
   input  byte_t       wdata,
   output logic        side,
   output logic [1:0]  drive_sel,
   output logic        motor_on,
   output logic        fdd_ready
);

   logic mounted;

   // the host pulses img_mounted on insert and on eject
   always_ff @(posedge reset or posedge clk) begin
      if (clk) begin
         mounted   <= 1'b0;
         side      <= 1'b0;
         drive_sel <= 2'b00;
         motor_on  <= 1'b0;
      end else begin
         if (img_mounted) begin
            mounted <= (img_size != 32'd0);
         end
         if (side_wr) begin
            side <= wdata[0];
         end
         if (drive_wr) begin
            drive_sel <= wdata[1:0];
            motor_on  <= wdata[7];
         end
      end
   end

   // only drive 0 has an image behind it
   assign fdd_ready = mounted & motor_on & (drive_sel == 2'b00);

endmodule

`default_nettype wire

//--- hw/fdc_disk_pkg.sv
`default_nettype none

package fdc_disk_pkg;

   typedef logic [6:0] track_t;
   typedef logic [7:0] sector_t;
   typedef logic [7:0] byte_t;

   // command classes the controller knows about
   typedef enum logic [2:0] {
      cmd_restore,
      cmd_seek,
      cmd_read_sector,
      cmd_force_int,
      cmd_unsupported
   } wd_cmd_e;

   // top nibble selects the command, multi-sector bit is ignored
   function automatic wd_cmd_e decode_cmd(input byte_t cmd);
      wd_cmd_e kind;
      casez (cmd)
         8'b0000_????: kind = cmd_restore;
         8'b0001_????: kind = cmd_seek;
         8'b100?_????: kind = cmd_read_sector;
         8'b1101_????: kind = cmd_force_int;
         default:      kind = cmd_unsupported;
      endcase
      return kind;
   endfunction

endpackage

`default_nettype wire

//--- hw/fdc_bus_pkg.sv
`default_nettype none

package fdc_bus_pkg;

   // controller register select, taken from addr[1:0]
   typedef enum logic [1:0] {
      reg_status_cmd = 2'd0,
      reg_track      = 2'd1,
      reg_sector     = 2'd2,
      reg_data       = 2'd3
   } wd_reg_e;

   // bit positions in the controller status byte
   typedef enum logic [2:0] {
      st_busy             = 3'd0,
      st_drq              = 3'd1,
      st_lost_data        = 3'd2,
      st_crc              = 3'd3,
      st_record_not_found = 3'd4,
      st_track0           = 3'd5,
      st_write_protect    = 3'd6,
      st_not_ready        = 3'd7
   } status_bit_e;

   // offsets inside the 4 KB I/O window
   localparam logic [11:0] io_wd_base = 12'hff8;
   localparam logic [11:0] io_side    = 12'hffc;
   localparam logic [11:0] io_drive   = 12'hffd;
   localparam logic [11:0] io_status  = 12'hfff;

endpackage

`default_nettype wire

//--- hw/fdc_config.svh
`ifndef FDC_CONFIG_SVH
`define FDC_CONFIG_SVH

// disk image geometry, single density layout with 256 byte sectors
`define FDC_SECTORS_PER_TRACK 10
`define FDC_SIDES             2
`define FDC_SECTOR_BYTES      256
`define FDC_TRACKS            80

// cycles the testbench allows for one line of the test file
`define FDC_TEST_CYCLES       3000

`endif
